//--- include/mdu_config.svh
`ifndef MDU_CONFIG_SVH
`define MDU_CONFIG_SVH

// register stages between the operation transfer and the finished product.
`define MDU_MUL_STAGES 3

// physical register index width.
`define MDU_PREG_BITS 6

// reorder-buffer id width.
`define MDU_ROB_BITS 5

`endif

//--- src/mduPkg.sv
`default_nettype none

package mduPkg;

`include "mdu_config.svh"

    typedef enum logic [1:0] {
        MDU_MULT  = 2'd0,    // signed multiply.
        MDU_MULTU = 2'd1,
        MDU_DIV   = 2'd2,    // signed divide.
        MDU_DIVU  = 2'd3
    } mduOp_e;

    // Write-back bookkeeping for both halves of one request.
    typedef struct packed {
        logic [`MDU_PREG_BITS-1:0] dstHi;
        logic [`MDU_PREG_BITS-1:0] dstLo;
        logic [`MDU_ROB_BITS-1:0]  robHi;
        logic [`MDU_ROB_BITS-1:0]  robLo;
    } mduTag_t;

endpackage

`default_nettype wire

//--- src/mduOpIf.sv
`timescale 1ns/1ps
`default_nettype none

interface mduOpIf import mduPkg::*; ();
    logic        valid;
    logic        ready;
    logic        isDiv;
    logic [31:0] magA;
    logic [31:0] magB;
    logic        negProd;
    logic        negQuot;
    logic        negRem;
    logic        divZero;
    logic [31:0] rawA;    // unmodified dividend, returned in HI on a zero divisor.
    mduTag_t     tag;

    modport producer(output valid, isDiv, magA, magB, negProd, negQuot, negRem, divZero,
                     rawA, tag, input ready);
    modport consumer(input valid, isDiv, magA, magB, negProd, negQuot, negRem, divZero,
                     rawA, tag, output ready);
endinterface

`default_nettype wire

//--- src/mduResIf.sv
`timescale 1ns/1ps
`default_nettype none

interface mduResIf import mduPkg::*; ();
    logic        valid;
    logic        ready;
    logic [31:0] hi;
    logic [31:0] lo;
    mduTag_t     tag;

    modport producer(
        output valid, hi, lo, tag,
        input  ready
    );

    modport consumer(
        input  valid, hi, lo, tag,
        output ready
    );
endinterface

`default_nettype wire

//--- src/mduDivider.sv
`timescale 1ns/1ps
`default_nettype none

module mduDivider (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    output logic        busy,
    output logic        done,
    input  logic        hold,
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    output logic [31:0] quotient,
    output logic [31:0] remainder
);

    logic [4:0]  iterCount;
    logic [31:0] remReg;
    logic [31:0] quoReg;
    logic [31:0] divisorReg;
    logic [32:0] shifted;
    logic [32:0] trial;

    // bring down the next dividend bit and try to subtract.
    assign shifted = {remReg, quoReg[31]};
    assign trial   = shifted - {1'b0, divisorReg};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            iterCount <= '0;
        end else if (start) begin
            busy      <= 1'b1;
            done      <= 1'b0;
            iterCount <= '0;
        end else if (busy) begin
            iterCount <= iterCount + 5'd1;
            if (iterCount == 5'd31) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else begin
            done <= done && hold;    // result stays up until it is taken.
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            remReg     <= '0;
            quoReg     <= dividend;
            divisorReg <= divisor;
        end else if (busy) begin
            if (!trial[32]) begin
                remReg <= trial[31:0];
            end else begin
                remReg <= shifted[31:0];    // restore, the subtraction went negative.
            end
            quoReg <= {quoReg[30:0], !trial[32]};
        end
    end

    assign quotient  = quoReg;
    assign remainder = remReg;

    assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

//--- src/mduDecode.sv
`timescale 1ns/1ps
`default_nettype none

module mduDecode import mduPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        reqValid,
    output logic        reqReady,
    input  mduOp_e      reqOp,
    input  logic [31:0] reqA,
    input  logic [31:0] reqB,
    input  mduTag_t     reqTag,
    mduOpIf.producer    op
);

    logic        isSigned;
    logic        isDiv;
    logic        signsDiffer;
    logic [31:0] magA;
    logic [31:0] magB;
    logic        reqFire;

    assign isSigned = (reqOp == MDU_MULT) || (reqOp == MDU_DIV);
    assign isDiv    = (reqOp == MDU_DIV) || (reqOp == MDU_DIVU);

    // magnitudes only differ from the raw values for negative signed operands.
    assign magA = (isSigned && reqA[31]) ? -reqA : reqA;
    assign magB = (isSigned && reqB[31]) ? -reqB : reqB;

    assign signsDiffer = isSigned && (reqA[31] ^ reqB[31]);

    assign reqReady = !op.valid || op.ready;
    assign reqFire  = reqValid && reqReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            op.valid <= 1'b0;
        end else if (reqFire) begin
            op.valid <= 1'b1;
        end else if (op.ready) begin
            op.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reqFire) begin
            op.isDiv   <= isDiv;
            op.magA    <= magA;
            op.magB    <= magB;
            op.negProd <= !isDiv && signsDiffer;
            op.negQuot <= isDiv && signsDiffer;
            op.negRem  <= isDiv && isSigned && reqA[31];    // remainder follows the dividend.
            op.divZero <= isDiv && (reqB == 32'd0);
            op.rawA    <= reqA;
            op.tag     <= reqTag;
        end
    end

endmodule

`default_nettype wire

//--- src/mduExecute.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mduExecute import mduPkg::*; (
    input  logic      clk,
    input  logic      rst,
    mduOpIf.consumer  op,
    mduResIf.producer res
);

    localparam int Stages = `MDU_MUL_STAGES;

    logic [Stages-1:0] mulValid;
    logic [63:0]       mulProd [Stages];
    logic              mulNeg  [Stages];
    mduTag_t           mulTag  [Stages];
    logic              mulEmpty;
    logic              mulAdvance;
    logic              mulFire;
    logic [63:0]       prodFix;

    logic        divStart;
    logic        divBusy;
    logic        divDone;
    logic        divIdle;
    logic [31:0] quotient;
    logic [31:0] remainder;
    logic        divNegQuot;
    logic        divNegRem;
    logic        divZero;
    logic [31:0] divRawA;
    mduTag_t     divTag;

    assign mulEmpty   = ~|mulValid;
    assign mulAdvance = !(mulValid[Stages-1] && !res.ready);    // the whole pipe stalls.
    assign divIdle    = !divBusy && !divDone;

    // a divide waits for the pipe to drain so completions stay in order.
    assign op.ready = op.isDiv ? (divIdle && mulEmpty) : (divIdle && mulAdvance);
    assign mulFire  = op.valid && op.ready && !op.isDiv;
    assign divStart = op.valid && op.ready && op.isDiv;

    always_ff @(posedge clk) begin
        if (rst) begin
            mulValid <= '0;
        end else if (mulAdvance) begin
            mulValid <= {mulValid[Stages-2:0], mulFire};
        end
    end

    always_ff @(posedge clk) begin
        if (mulAdvance) begin
            mulProd[0] <= 64'(op.magA) * 64'(op.magB);
            mulNeg[0]  <= op.negProd;
            mulTag[0]  <= op.tag;
            for (int i = 1; i < Stages; i++) begin
                mulProd[i] <= mulProd[i-1];
                mulNeg[i]  <= mulNeg[i-1];
                mulTag[i]  <= mulTag[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (divStart) begin
            divNegQuot <= op.negQuot;
            divNegRem  <= op.negRem;
            divZero    <= op.divZero;
            divRawA    <= op.rawA;
            divTag     <= op.tag;
        end
    end

    mduDivider divider (
        .clk       (clk),
        .rst       (rst),
        .start     (divStart),
        .busy      (divBusy),
        .done      (divDone),
        .hold      (!res.ready),
        .dividend  (op.magA),
        .divisor   (op.magB),
        .quotient  (quotient),
        .remainder (remainder)
    );

    assign prodFix = mulNeg[Stages-1] ? -mulProd[Stages-1] : mulProd[Stages-1];

    assign res.valid = mulValid[Stages-1] || divDone;

    always_comb begin
        if (mulValid[Stages-1]) begin
            res.hi  = prodFix[63:32];
            res.lo  = prodFix[31:0];
            res.tag = mulTag[Stages-1];
        end else if (divZero) begin
            res.hi  = divRawA;
            res.lo  = 32'hffff_ffff;
            res.tag = divTag;
        end else begin
            res.hi  = divNegRem ? -remainder : remainder;
            res.lo  = divNegQuot ? -quotient : quotient;    // 80000000 / -1 wraps here.
            res.tag = divTag;
        end
    end

    // no multiply is in flight while the divider holds an operation.
    assert property (@(posedge clk) disable iff (rst) divBusy || divDone |-> mulEmpty);

    assert property (@(posedge clk) disable iff (rst)
        res.valid && !res.ready |=> res.valid && $stable(res.hi) && $stable(res.lo));

endmodule

`default_nettype wire

//--- src/mduResult.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mduResult import mduPkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    mduResIf.consumer                 res,
    output logic                      wbEn,
    output logic [`MDU_PREG_BITS-1:0] wbDst,
    output logic [31:0]               wbData,
    output logic [`MDU_ROB_BITS-1:0]  wbRobId
);

    typedef enum logic [1:0] {
        idle,
        outHi,
        outLo
    } resState_e;

    resState_e   state;
    logic [31:0] hiReg;
    logic [31:0] loReg;
    mduTag_t     tagReg;
    logic        accept;

    // a new pair can be taken while the LO beat goes out.
    assign res.ready = (state != outHi);
    assign accept    = res.valid && res.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        state <= outHi;
                    end
                end
                outHi: begin
                    state <= outLo;
                end
                outLo: begin
                    state <= accept ? outHi : idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hiReg  <= res.hi;
            loReg  <= res.lo;
            tagReg <= res.tag;
        end
    end

    assign wbEn    = (state == outHi) || (state == outLo);
    assign wbData  = (state == outLo) ? loReg : hiReg;
    assign wbDst   = (state == outLo) ? tagReg.dstLo : tagReg.dstHi;
    assign wbRobId = (state == outLo) ? tagReg.robLo : tagReg.robHi;

    // a pair that is held back keeps its tag, so both beats reach the right registers.
    assert property (@(posedge clk) disable iff (rst)
        res.valid && !res.ready |=> res.valid && $stable(res.tag));

endmodule

`default_nettype wire

//--- src/mduTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mduTop import mduPkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      reqValid,
    output logic                      reqReady,
    input  mduOp_e                    reqOp,
    input  logic [31:0]               reqA,
    input  logic [31:0]               reqB,
    input  logic [`MDU_PREG_BITS-1:0] reqDstHi,
    input  logic [`MDU_PREG_BITS-1:0] reqDstLo,
    input  logic [`MDU_ROB_BITS-1:0]  reqRobHi,
    input  logic [`MDU_ROB_BITS-1:0]  reqRobLo,
    output logic                      wbEn,
    output logic [`MDU_PREG_BITS-1:0] wbDst,
    output logic [31:0]               wbData,
    output logic [`MDU_ROB_BITS-1:0]  wbRobId
);

    mduTag_t reqTag;
    mduOpIf  opBus ();
    mduResIf resBus ();

    assign reqTag.dstHi = reqDstHi;
    assign reqTag.dstLo = reqDstLo;
    assign reqTag.robHi = reqRobHi;
    assign reqTag.robLo = reqRobLo;

    mduDecode decode (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .reqOp    (reqOp),
        .reqA     (reqA),
        .reqB     (reqB),
        .reqTag   (reqTag),
        .op       (opBus.producer)
    );

    mduExecute execute (
        .clk (clk),
        .rst (rst),
        .op  (opBus.consumer),
        .res (resBus.producer)
    );

    mduResult result (
        .clk     (clk),
        .rst     (rst),
        .res     (resBus.consumer),
        .wbEn    (wbEn),
        .wbDst   (wbDst),
        .wbData  (wbData),
        .wbRobId (wbRobId)
    );

endmodule

`default_nettype wire

//--- sim/mduTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_config.svh"

module mduTb import mduPkg::*; ();

    localparam int PregBits    = `MDU_PREG_BITS;
    localparam int RobBits     = `MDU_ROB_BITS;
    localparam int MulLat      = `MDU_MUL_STAGES + 2;
    localparam int DivLat      = 35;
    localparam int NumDirected = 24;
    localparam int NumRandom   = 200;
    localparam int CycleLimit  = (NumDirected + NumRandom) * 40 + 200;

    typedef struct packed {
        logic [31:0]         data;
        logic [PregBits-1:0] dst;
        logic [RobBits-1:0]  rob;
        logic                chkLat;    // set on the HI beat of a request that found the unit empty.
        logic                follows;   // must come in the cycle right after the previous beat.
        logic                fromDiv;
        int                  due;
    } beat_t;

    logic                clk;
    logic                rst;
    logic                reqValid;
    logic                reqReady;
    mduOp_e              reqOp;
    logic [31:0]         reqA;
    logic [31:0]         reqB;
    logic [PregBits-1:0] reqDstHi;
    logic [PregBits-1:0] reqDstLo;
    logic [RobBits-1:0]  reqRobHi;
    logic [RobBits-1:0]  reqRobLo;
    logic                wbEn;
    logic [PregBits-1:0] wbDst;
    logic [31:0]         wbData;
    logic [RobBits-1:0]  wbRobId;

    beat_t  expQ[$];
    beat_t  head;
    logic   headValid   = 1'b0;
    logic   burst       = 1'b0;    // requests go out back to back.
    int     cycle       = 0;
    int     stallCycles = 0;
    int     sent        = 0;
    int     dataErrors  = 0;
    int     tagErrors   = 0;
    int     otherErrors = 0;
    integer seed;

    mduTop UUT (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .reqOp    (reqOp),
        .reqA     (reqA),
        .reqB     (reqB),
        .reqDstHi (reqDstHi),
        .reqDstLo (reqDstLo),
        .reqRobHi (reqRobHi),
        .reqRobLo (reqRobLo),
        .wbEn     (wbEn),
        .wbDst    (wbDst),
        .wbData   (wbData),
        .wbRobId  (wbRobId)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // returns {HI, LO} from the architectural rules of each opcode.
    function automatic logic [63:0] expectPair(mduOp_e opc, logic [31:0] a, logic [31:0] b);
        longint      sa;
        longint      sb;
        logic [63:0] r;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (opc)
            MDU_MULT:  r = sa * sb;
            MDU_MULTU: r = {32'd0, a} * {32'd0, b};
            MDU_DIV:   r = (b == 32'd0) ? {a, 32'hffff_ffff} : {32'(sa % sb), 32'(sa / sb)};
            default:   r = (b == 32'd0) ? {a, 32'hffff_ffff} : {a % b, a / b};
        endcase
        return r;
    endfunction

    task automatic printSummary();
        $display("errors: data %0d, tag %0d, other %0d", dataErrors, tagErrors, otherErrors);
    endtask

    task automatic sendReq(input mduOp_e opc, input logic [31:0] a, input logic [31:0] b);
        reqValid <= 1'b1;
        reqOp    <= opc;
        reqA     <= a;
        reqB     <= b;
        reqDstHi <= PregBits'(2 * sent);
        reqDstLo <= PregBits'(2 * sent + 1);
        reqRobHi <= RobBits'(2 * sent + 5);
        reqRobLo <= RobBits'(2 * sent + 6);
        do begin
            @(posedge clk);
        end while (!reqReady);
        sent++;
    endtask

    task automatic idleCycles(input int n);
        reqValid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic drain();
        reqValid <= 1'b0;
        @(posedge clk);
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic runIsolated(input mduOp_e opc, input logic [31:0] a, input logic [31:0] b);
        sendReq(opc, a, b);
        drain();
    endtask

    // reference model, two beats per accepted request.
    always @(posedge clk) begin
        logic [63:0] pair;
        beat_t       hiBeat;
        beat_t       loBeat;
        if (!rst) begin
            if (wbEn && expQ.size() > 0) begin
                void'(expQ.pop_front());
            end
            if (reqValid && reqReady) begin
                pair           = expectPair(reqOp, reqA, reqB);
                hiBeat.data    = pair[63:32];
                hiBeat.dst     = reqDstHi;
                hiBeat.rob     = reqRobHi;
                hiBeat.chkLat  = (expQ.size() == 0);
                hiBeat.follows = burst && (expQ.size() != 0);
                hiBeat.fromDiv = (reqOp == MDU_DIV) || (reqOp == MDU_DIVU);
                hiBeat.due     = cycle + (hiBeat.fromDiv ? DivLat : MulLat);
                loBeat         = hiBeat;
                loBeat.data    = pair[31:0];
                loBeat.dst     = reqDstLo;
                loBeat.rob     = reqRobLo;
                loBeat.chkLat  = 1'b0;
                loBeat.follows = 1'b1;
                expQ.push_back(hiBeat);
                expQ.push_back(loBeat);
            end
            if (expQ.size() > 0) begin
                headValid <= 1'b1;
                head      <= expQ[0];
            end else begin
                headValid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!rst && reqValid && !reqReady && headValid && head.fromDiv) begin
            stallCycles <= stallCycles + 1;
        end
        if (cycle >= CycleLimit) begin
            $display("timeout: no finish after %0d cycles", cycle);
            printSummary();
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    assert property (@(posedge clk) disable iff (rst) wbEn |-> headValid)
        else begin
            otherErrors++;
            $display("write-back beat at cycle %0d with no request outstanding", cycle);
        end

    assert property (@(posedge clk) disable iff (rst) wbEn && headValid |-> wbData == head.data)
        else begin
            dataErrors++;
            $display("Error: wbData = 0x%08h, expected 0x%08h", $sampled(wbData),
                     $sampled(head.data));
        end

    assert property (@(posedge clk) disable iff (rst) wbEn && headValid |-> wbDst == head.dst)
        else begin
            tagErrors++;
            $display("Error: wbDst = 0x%02h, expected 0x%02h", $sampled(wbDst), $sampled(head.dst));
        end

    assert property (@(posedge clk) disable iff (rst) wbEn && headValid |-> wbRobId == head.rob)
        else begin
            tagErrors++;
            $display("Error: wbRobId = 0x%02h, expected 0x%02h", $sampled(wbRobId),
                     $sampled(head.rob));
        end

    assert property (@(posedge clk) disable iff (rst)
        wbEn && headValid && head.chkLat |-> cycle == head.due)
        else begin
            otherErrors++;
            $display("HI beat came at cycle %0d but was due at cycle %0d", $sampled(cycle),
                     $sampled(head.due));
        end

    assert property (@(posedge clk) disable iff (rst)
        wbEn && headValid && head.follows |-> $past(wbEn))
        else begin
            otherErrors++;
            $display("gap before the write-back beat for register 0x%02h", $sampled(head.dst));
        end

    initial begin
        logic [1:0]  opBits;
        logic [31:0] a;
        logic [31:0] b;
        int          gap;
        seed     = 13;
        rst      = 1'b1;
        reqValid = 1'b0;
        reqOp    = MDU_MULT;
        reqA     = 32'd0;
        reqB     = 32'd0;
        reqDstHi = '0;
        reqDstLo = '0;
        reqRobHi = '0;
        reqRobLo = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        runIsolated(MDU_MULT, 32'd7, 32'd9);
        runIsolated(MDU_MULT, -32'd7, 32'd9);
        runIsolated(MDU_MULT, 32'd7, -32'd9);
        runIsolated(MDU_MULT, -32'd7, -32'd9);
        runIsolated(MDU_MULT, 32'h8000_0000, 32'h8000_0000);
        runIsolated(MDU_MULTU, 32'hffff_ffff, 32'hffff_ffff);
        runIsolated(MDU_MULTU, 32'h8000_0000, 32'h8000_0000);
        runIsolated(MDU_MULTU, 32'h1234_5678, 32'h9abc_def0);

        runIsolated(MDU_DIV, 32'd100, 32'd7);
        runIsolated(MDU_DIV, -32'd100, 32'd7);    // remainder takes the dividend sign.
        runIsolated(MDU_DIV, 32'd100, -32'd7);
        runIsolated(MDU_DIV, -32'd100, -32'd7);
        runIsolated(MDU_DIV, 32'h8000_0000, 32'hffff_ffff);
        runIsolated(MDU_DIVU, 32'hffff_ffff, 32'd7);
        runIsolated(MDU_DIVU, 32'h8000_0000, 32'hffff_ffff);

        runIsolated(MDU_DIV, 32'd1234, 32'd0);
        runIsolated(MDU_DIV, -32'd5, 32'd0);
        runIsolated(MDU_DIVU, 32'hffff_ffff, 32'd0);

        burst = 1'b1;
        for (int i = 0; i < 6; i++) begin
            sendReq((i % 2 == 0) ? MDU_MULT : MDU_MULTU, 32'(3 * i + 1), -32'(i + 2));
        end
        drain();
        burst = 1'b0;

        for (int i = 0; i < NumRandom; i++) begin
            opBits = 2'($random(seed));
            a      = $random(seed);
            case ($random(seed) & 7)
                0:       b = 32'd0;
                1:       b = 32'hffff_ffff;
                2:       b = 32'($random(seed) & 15);
                default: b = $random(seed);
            endcase
            sendReq(mduOp_e'(opBits), a, b);
            gap = $random(seed) & 3;
            if (gap != 0) begin
                idleCycles(gap);
            end
        end
        drain();
        repeat (2) @(posedge clk);

        if (stallCycles == 0) begin
            otherErrors++;
            $display("reqReady never dropped while a divide was in flight");
        end
        printSummary();
        if (dataErrors + tagErrors + otherErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
src/mduPkg.sv
src/mduOpIf.sv
src/mduResIf.sv
src/mduDivider.sv
src/mduDecode.sv
src/mduExecute.sv
src/mduResult.sv
src/mduTop.sv
sim/mduTb.sv

//--- Bender.yml
package:
  name: mdu

sources:
  - include_dirs:
      - include
    files:
      - src/mduPkg.sv
      - src/mduOpIf.sv
      - src/mduResIf.sv
      - src/mduDivider.sv
      - src/mduDecode.sv
      - src/mduExecute.sv
      - src/mduResult.sv
      - src/mduTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/mduTb.sv
